// File: hw/credit_fifo.sv
module credit_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk_in,
    input  logic rst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic not_empty,
    output logic credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // circular pointer step
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign not_empty = (count != '0);
    assign do_pop    = pop & not_empty;
    // head entry, only meaningful while not_empty
    assign pop_data  = mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            count  <= count + CNT_W'(push) - CNT_W'(do_pop);
            // freed entry goes back to the producer next cycle
            credit <= do_pop;
        end
    end

endmodule

// File: hw/decimator.sv
`include "mic_cfg.svh"

module decimator
    import mic_pkg::*;
(
    input  logic clk_in,
    input  logic rst_n,
    input  logic fir_valid,
    input  acc_t fir_data,
    output logic fir_credit,
    output logic out_valid,
    output acc_t out_data,
    input  logic out_credit
);

    localparam int PH_W  = $clog2(`MIC_DECIM);
    localparam int CRD_W = $clog2(`MIC_OUT_CREDITS + 1);

    // position of the next fir output within the decimation period
    logic [PH_W-1:0]  phase;
    logic             keep;
    logic             discard;
    logic             fifo_credit;
    // a credit that collided with another one and waits a cycle
    logic             pend;
    logic [1:0]       owed;
    logic             not_empty;
    logic             pop;
    acc_t             pop_data;
    logic [CRD_W-1:0] out_credits;

    credit_fifo #(
        .T     (acc_t),
        .DEPTH (`MIC_FIFO_DEPTH)
    ) keep_fifo_inst (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .push      (keep),
        .push_data (fir_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .not_empty (not_empty),
        .credit    (fifo_credit)
    );

    assign keep       = fir_valid & (phase == '0);
    assign discard    = fir_valid & (phase != '0);
    // fir outputs are many cycles apart, so at most one credit is ever deferred
    assign owed       = 2'(discard) + 2'(fifo_credit) + 2'(pend);
    assign fir_credit = (owed != 2'd0);
    assign pop        = not_empty & (out_credits != '0);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            phase       <= '0;
            pend        <= 1'b0;
            out_valid   <= 1'b0;
            out_credits <= CRD_W'(`MIC_OUT_CREDITS);
        end else begin
            if (fir_valid) begin
                phase <= (phase == PH_W'(`MIC_DECIM - 1)) ? '0 : phase + 1'b1;
            end
            pend        <= (owed > 2'd1);
            out_valid   <= pop;
            out_credits <= out_credits - CRD_W'(pop) + CRD_W'(out_credit);
        end
    end

    always_ff @(posedge clk_in) begin
        if (pop) begin
            out_data <= pop_data;
        end
    end

endmodule

// File: hw/fir_lowpass.sv
`include "mic_cfg.svh"

module fir_lowpass
    import mic_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_n,
    input  logic    rx_valid,
    input  sample_t rx_data,
    output logic    rx_credit,
    output logic    fir_valid,
    output acc_t    fir_data,
    input  logic    fir_credit
);

    localparam int TAP_W = $clog2(`MIC_TAPS);
    localparam int CRD_W = $clog2(`MIC_FIFO_DEPTH + 1);
    localparam logic [`MIC_TAPS*`MIC_COEF_BITS-1:0] COEFS = `MIC_FIR_COEFS;

    typedef enum logic [1:0] {
        S_IDLE,
        S_MAC,
        S_OUT
    } state_t;

    state_t                    state;
    // hist[0] is the newest sample
    sample_t                   hist [`MIC_TAPS];
    sample_t                   in_data;
    logic                      in_ready;
    logic                      pop;
    logic [TAP_W-1:0]          tap;
    logic [`MIC_COEF_BITS-1:0] coef;
    acc_t                      acc;
    acc_t                      mac_sum;
    logic                      last_tap;
    logic                      send;
    logic [CRD_W-1:0]          credits;

    credit_fifo #(
        .T     (sample_t),
        .DEPTH (`MIC_FIFO_DEPTH)
    ) in_fifo_inst (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .push      (rx_valid),
        .push_data (rx_data),
        .pop       (pop),
        .pop_data  (in_data),
        .not_empty (in_ready),
        .credit    (rx_credit)
    );

    // take a new sample only between outputs
    assign pop      = (state == S_IDLE) & in_ready;
    assign coef     = COEFS[tap*`MIC_COEF_BITS +: `MIC_COEF_BITS];
    // one tap per clock, coefficients are positive
    assign mac_sum  = acc + acc_t'(hist[tap]) * acc_t'($signed({1'b0, coef}));
    assign last_tap = (state == S_MAC) & (tap == TAP_W'(`MIC_TAPS - 1));
    assign send     = (last_tap | (state == S_OUT)) & (credits != '0);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            tap       <= '0;
            acc       <= '0;
            fir_valid <= 1'b0;
            credits   <= CRD_W'(`MIC_FIFO_DEPTH);
            // history starts silent
            for (int i = 0; i < `MIC_TAPS; i++) begin
                hist[i] <= '0;
            end
        end else begin
            fir_valid <= send;
            credits   <= credits - CRD_W'(send) + CRD_W'(fir_credit);
            case (state)
                S_IDLE: begin
                    if (in_ready) begin
                        hist[0] <= in_data;
                        for (int i = 1; i < `MIC_TAPS; i++) begin
                            hist[i] <= hist[i-1];
                        end
                        acc   <= '0;
                        tap   <= '0;
                        state <= S_MAC;
                    end
                end
                S_MAC: begin
                    acc <= mac_sum;
                    tap <= tap + 1'b1;
                    // emit at once when a credit is there, else park the sum
                    if (last_tap) begin
                        state <= send ? S_IDLE : S_OUT;
                    end
                end
                S_OUT: begin
                    if (send) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (send) begin
            fir_data <= (state == S_OUT) ? acc : mac_sum;
        end
    end

endmodule

// File: hw/i2s_clock_gen.sv
`include "mic_cfg.svh"

module i2s_clock_gen (
    input  logic clk_in,
    input  logic rst_n,
    output logic sck,
    output logic ws
);

    localparam int DIV_W      = $clog2(`MIC_SCK_HALF + 1);
    localparam int HALF_FRAME = `MIC_FRAME_BITS / 2;
    localparam int BIT_W      = $clog2(HALF_FRAME);

    // clk_in cycles spent in the current sck level
    logic [DIV_W-1:0] div_cnt;
    // sck periods completed in the current ws half
    logic [BIT_W-1:0] bit_cnt;
    logic             half_done;
    logic             sck_fall;

    assign half_done = (div_cnt == DIV_W'(`MIC_SCK_HALF - 1));
    // sck is about to go low on this edge
    assign sck_fall  = half_done & sck;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
            ws      <= 1'b0;
        end else begin
            if (half_done) begin
                div_cnt <= '0;
                sck     <= ~sck;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            // ws only moves together with a falling sck
            if (sck_fall) begin
                if (bit_cnt == BIT_W'(HALF_FRAME - 1)) begin
                    bit_cnt <= '0;
                    ws      <= ~ws;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/i2s_receiver.sv
`include "mic_cfg.svh"

module i2s_receiver
    import mic_pkg::*;
(
    input  logic    clk_in,
    input  logic    rst_n,
    input  logic    sck,
    input  logic    ws,
    input  logic    sd,
    output logic    rx_valid,
    output sample_t rx_data,
    input  logic    rx_credit,
    output logic    overrun
);

    localparam int CNT_W = $clog2(`MIC_SAMPLE_BITS + 1);
    localparam int CRD_W = $clog2(`MIC_FIFO_DEPTH + 1);

    logic             sck_q;
    logic             ws_q;
    logic             sck_rise;
    logic             ws_fall;
    // inside the left half of a frame, still collecting bits
    logic             active;
    // rise 0 is the one-bit delay, rises 1..24 carry data
    logic [CNT_W-1:0] rise_cnt;
    logic             data_rise;
    logic             last_bit;
    logic             send;
    logic [CRD_W-1:0] credits;

    assign sck_rise  = sck & ~sck_q;
    assign ws_fall   = ~ws & ws_q;
    assign data_rise = active & sck_rise & (rise_cnt != '0);
    assign last_bit  = data_rise & (rise_cnt == CNT_W'(`MIC_SAMPLE_BITS));
    assign send      = last_bit & (credits != '0);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            sck_q    <= 1'b0;
            // ws starts low, so the first frame already counts as a fall
            ws_q     <= 1'b1;
            active   <= 1'b0;
            rise_cnt <= '0;
            rx_valid <= 1'b0;
            overrun  <= 1'b0;
            credits  <= CRD_W'(`MIC_FIFO_DEPTH);
        end else begin
            sck_q    <= sck;
            ws_q     <= ws;
            rx_valid <= send;
            credits  <= credits - CRD_W'(send) + CRD_W'(rx_credit);
            // no room downstream, the sample is lost
            if (last_bit && !send) begin
                overrun <= 1'b1;
            end
            if (ws_fall) begin
                active   <= 1'b1;
                rise_cnt <= '0;
            end else if (active && sck_rise) begin
                rise_cnt <= rise_cnt + 1'b1;
                if (last_bit) begin
                    active <= 1'b0;
                end
            end
        end
    end

    // MSB first, the final shift lands with rx_valid
    always_ff @(posedge clk_in) begin
        if (data_rise) begin
            rx_data <= {rx_data[`MIC_SAMPLE_BITS-2:0], sd};
        end
    end

endmodule

// File: hw/mic_cfg.svh
`ifndef MIC_CFG_SVH
`define MIC_CFG_SVH

// clk_in cycles per sck half period, so one sck period is twice this
`define MIC_SCK_HALF 2

// sck periods per ws frame, ws toggles at half frame
`define MIC_FRAME_BITS 64

// sample width delivered by the microphone
`define MIC_SAMPLE_BITS 24

// accumulator and output word width
`define MIC_ACC_BITS 32

// low-pass FIR, tap 0 sits in the low byte, gain is 20
`define MIC_TAPS 8
`define MIC_COEF_BITS 8
`define MIC_FIR_COEFS {8'd1, 8'd2, 8'd3, 8'd4, 8'd4, 8'd3, 8'd2, 8'd1}

// keep one filtered sample in every MIC_DECIM
`define MIC_DECIM 8

// entries per inter-stage buffer and initial credits at the output port
`define MIC_FIFO_DEPTH 2
`define MIC_OUT_CREDITS 2

`endif

// File: hw/mic_pkg.sv
`include "mic_cfg.svh"

package mic_pkg;

    // raw left-channel sample as shifted in from the microphone
    // two's complement, MSB first on the wire
    typedef logic signed [`MIC_SAMPLE_BITS-1:0] sample_t;

    // filter accumulator, also the word leaving the decimator
    // wide enough for the full-scale sample times the coefficient sum
    typedef logic signed [`MIC_ACC_BITS-1:0] acc_t;

endpackage

// File: hw/microphones.sv
module microphones
    import mic_pkg::*;
(
    input  logic clk_in,
    input  logic rst_n,

    // microphone pins
    input  logic mic_data,
    output logic mic_sck,
    output logic mic_ws,

    // filtered, decimated stream
    output logic out_valid,
    output acc_t out_data,
    input  logic out_credit,

    // sticky, a sample was dropped at the receiver
    output logic overrun
);

    // receiver to filter
    logic    rx_valid;
    sample_t rx_data;
    logic    rx_credit;

    // filter to decimator
    logic    fir_valid;
    acc_t    fir_data;
    logic    fir_credit;

    // the board is the I2S controller, sck and ws come from here
    i2s_clock_gen i2s_clock_gen_inst (
        .clk_in (clk_in),
        .rst_n  (rst_n),
        .sck    (mic_sck),
        .ws     (mic_ws)
    );

    // receiver follows the same sck and ws that leave the chip
    i2s_receiver i2s_receiver_inst (
        .clk_in    (clk_in),
        .rst_n     (rst_n),
        .sck       (mic_sck),
        .ws        (mic_ws),
        .sd        (mic_data),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_credit (rx_credit),
        .overrun   (overrun)
    );

    fir_lowpass fir_lowpass_inst (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_credit  (rx_credit),
        .fir_valid  (fir_valid),
        .fir_data   (fir_data),
        .fir_credit (fir_credit)
    );

    decimator decimator_inst (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .fir_valid  (fir_valid),
        .fir_data   (fir_data),
        .fir_credit (fir_credit),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit)
    );

endmodule

// File: microphones.f
+incdir+hw
hw/mic_pkg.sv
hw/i2s_clock_gen.sv
hw/credit_fifo.sv
hw/i2s_receiver.sv
hw/fir_lowpass.sv
hw/decimator.sv
hw/microphones.sv
testbench/tb_microphones.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_microphones \
    -f microphones.f --Mdir obj_dir -o sim_microphones > build.log 2>&1 &&
./obj_dir/sim_microphones > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; } ||
{ echo "simulation passed"; exit 0; }

// File: testbench/tb_microphones.sv
`include "mic_cfg.svh"

module tb_microphones
    import mic_pkg::*;
();

    localparam int HALF_FRAME_SCK = `MIC_FRAME_BITS / 2;
    localparam int SCK_CLKS       = 2 * `MIC_SCK_HALF;
    localparam int FRAME_CLKS     = `MIC_FRAME_BITS * SCK_CLKS;
    localparam int STALL_FRAMES   = 40;
    // frames each test may take, in run order
    localparam int TEST_FRAMES    = 1 + 2 + 18 + 34 + 42;
    localparam int LIMIT_CYCLES   = TEST_FRAMES * FRAME_CLKS + 2000;
    localparam logic [`MIC_TAPS*`MIC_COEF_BITS-1:0] COEFS = `MIC_FIR_COEFS;

    logic        clk_in;
    logic        rst_n      = 1'b0;
    logic        mic_data   = 1'b0;
    logic        out_credit = 1'b0;
    logic        mic_sck;
    logic        mic_ws;
    logic        out_valid;
    acc_t        out_data;
    logic        overrun;

    // samples for the next test go to the mic model during reset
    sample_t     stim_q [$];
    sample_t     mic_q [$];
    // left samples that actually went out on the wire
    sample_t     sent_q [$];
    acc_t        got_q [$];
    bit          credit_auto = 1'b1;
    int          owed;
    logic [15:0] lfsr = 16'd37;
    int          cycle;
    int          errors;
    int          checks;
    int          tests_run;
    int          errors_before;
    string       test_name;

    // mic model state
    logic        sck_seen;
    logic        ws_seen;
    int          bit_pos;
    sample_t     cur;

    microphones u_dut (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .mic_data   (mic_data),
        .mic_sck    (mic_sck),
        .mic_ws     (mic_ws),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_credit (out_credit),
        .overrun    (overrun)
    );

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    // watchdog
    always @(posedge clk_in) begin
        cycle = cycle + 1;
        if (cycle > LIMIT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", LIMIT_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_next(lfsr);
        return lfsr[0];
    endfunction

    function automatic sample_t random_sample();
        sample_t s;
        s = '0;
        for (int b = 0; b < `MIC_SAMPLE_BITS; b++) begin
            s = {s[`MIC_SAMPLE_BITS-2:0], random_bit()};
        end
        return s;
    endfunction

    // 8-tap sum over the samples sent so far with silence before the first
    function automatic longint fir_reference(input int n);
        longint sum;
        sum = 0;
        for (int k = 0; k < `MIC_TAPS; k++) begin
            if (n - k >= 0) begin
                sum += longint'(sent_q[n-k])
                    * longint'(COEFS[k*`MIC_COEF_BITS +: `MIC_COEF_BITS]);
            end
        end
        return sum;
    endfunction

    // I2S microphone model puts out a new bit after every sck fall
    always @(posedge clk_in) begin
        if (!rst_n) begin
            sck_seen = 1'b0;
            ws_seen  = 1'b0;
            bit_pos  = 0;
            cur      = '0;
            mic_data <= 1'b0;
        end else begin
            if (sck_seen && !mic_sck) begin
                // ws moved with this fall so the next rise is the delay bit
                if (mic_ws != ws_seen) begin
                    ws_seen = mic_ws;
                    bit_pos = 0;
                end else begin
                    bit_pos++;
                end
                if (ws_seen) begin
                    // right channel is noise
                    mic_data <= random_bit();
                end else if (bit_pos == 0 || bit_pos > `MIC_SAMPLE_BITS) begin
                    mic_data <= 1'b0;
                end else begin
                    if (bit_pos == 1) begin
                        if (mic_q.size() != 0) begin
                            cur = mic_q.pop_front();
                        end else begin
                            cur = '0;
                        end
                        sent_q.push_back(cur);
                    end
                    // MSB first
                    mic_data <= cur[`MIC_SAMPLE_BITS - bit_pos];
                end
            end
            sck_seen = mic_sck;
        end
    end

    // output sink returns one credit the cycle after each beat
    always @(posedge clk_in) begin
        if (!rst_n) begin
            owed = 0;
            out_credit <= 1'b0;
        end else begin
            if (out_valid) begin
                got_q.push_back(out_data);
                owed++;
            end
            if (credit_auto && owed > 0) begin
                out_credit <= 1'b1;
                owed--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    task automatic check_eq(input string what, input logic signed [63:0] got,
                            input logic signed [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s is %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    // 5 cycles of reset while the stimulus is handed to the mic model
    task automatic apply_reset();
        rst_n <= 1'b0;
        repeat (5) @(posedge clk_in);
        mic_q = stim_q;
        stim_q.delete();
        sent_q.delete();
        got_q.delete();
        rst_n <= 1'b1;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_before);
        end
    endtask

    task automatic wait_sck_rise(output int clocks);
        logic last;
        logic rose;
        clocks = 0;
        rose   = 1'b0;
        while (!rose) begin
            last = mic_sck;
            @(posedge clk_in);
            clocks++;
            rose = mic_sck & ~last;
        end
    endtask

    task automatic wait_ws_toggle(output int clocks);
        logic last;
        last   = mic_ws;
        clocks = 0;
        while (mic_ws == last) begin
            @(posedge clk_in);
            clocks++;
        end
    endtask

    task automatic test_reset_state();
        start_test("reset state");
        apply_reset();
        check_eq("mic_sck after reset", mic_sck, 0);
        check_eq("mic_ws after reset", mic_ws, 0);
        check_eq("out_valid after reset", out_valid, 0);
        check_eq("overrun after reset", overrun, 0);
        end_test();
    endtask

    task automatic test_clock_timing();
        int clocks;
        start_test("clock timing");
        apply_reset();
        wait_sck_rise(clocks);
        wait_sck_rise(clocks);
        check_eq("clocks per sck period", clocks, SCK_CLKS);
        // the first toggle aligns and the second measures one half frame
        wait_ws_toggle(clocks);
        wait_ws_toggle(clocks);
        check_eq("clocks between ws toggles", clocks, HALF_FRAME_SCK * SCK_CLKS);
        end_test();
    endtask

    task automatic test_constant_input();
        sample_t x;
        x = -24'sd12345;
        start_test("constant input");
        credit_auto = 1'b1;
        for (int i = 0; i < 24; i++) begin
            stim_q.push_back(x);
        end
        apply_reset();
        while (got_q.size() < 3) @(posedge clk_in);
        // output 0 still sees the silent history
        for (int j = 1; j < 3; j++) begin
            check_eq($sformatf("constant output %0d", j), got_q[j], longint'(x) * 20);
        end
        check_eq("overrun with constant input", overrun, 0);
        end_test();
    endtask

    task automatic test_random_stream();
        start_test("random stream");
        credit_auto = 1'b1;
        for (int i = 0; i < 40; i++) begin
            stim_q.push_back(random_sample());
        end
        apply_reset();
        while (got_q.size() < 5) @(posedge clk_in);
        for (int j = 0; j < 5; j++) begin
            check_eq($sformatf("random output %0d", j), got_q[j],
                     fir_reference(j * `MIC_DECIM));
        end
        check_eq("overrun with credits returned", overrun, 0);
        end_test();
    endtask

    task automatic test_credit_stall();
        start_test("credit stall");
        credit_auto = 1'b0;
        for (int i = 0; i < 40; i++) begin
            stim_q.push_back(random_sample());
        end
        apply_reset();
        // hold back every output credit for the whole stall
        repeat (STALL_FRAMES * FRAME_CLKS) @(posedge clk_in);
        check_eq("outputs while stalled", got_q.size(), `MIC_OUT_CREDITS);
        check_eq("overrun while stalled", overrun, 1);
        if (got_q.size() >= 2) begin
            check_eq("stalled output 0", got_q[0], fir_reference(0));
            check_eq("stalled output 1", got_q[1], fir_reference(`MIC_DECIM));
        end
        credit_auto = 1'b1;
        while (got_q.size() <= `MIC_OUT_CREDITS) @(posedge clk_in);
        check_eq("overrun after credits resume", overrun, 1);
        end_test();
    endtask

    initial begin
        test_reset_state();
        test_clock_timing();
        test_constant_input();
        test_random_stream();
        test_credit_stall();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
